// ==== filelist.f ====
logic/ossc_pkg.sv
logic/sys_reset_gen.sv
logic/sys_ctrl_regs.sv
logic/front_panel.sv
logic/capture_mux.sv
logic/osd_overlay.sv
logic/ossc_top.sv
dv/ossc_assert.sv
dv/ossc_tb.sv

// ==== Makefile ====
# Verilator flow for the scan converter glue logic

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module ossc_tb

sim:
	verilator --binary --timing --assert -f filelist.f --top-module ossc_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vossc_tb); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

// ==== dv/ossc_tb.sv ====
/*
 * Testbench for ossc_top. Inputs change on the falling edge and outputs are
 * sampled there as well. Video is compared only while a stream is running.
 */
`default_nettype none

module ossc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'hf5426da7;
    localparam int STREAM_LEN = 40;
    localparam int N_STREAMS  = 6;
    localparam int DRAIN      = 8;
    // edges between the sampling edge of an input and the edge that shows it
    localparam int ISL_LAT    = 3;
    localparam int HDMI_LAT   = 4;
    localparam int TIMEOUT_CYCLES = 4 + ossc_pkg::PO_HOLD_CYCLES + 40
        + N_STREAMS * (STREAM_LEN + DRAIN) + 20 + ossc_pkg::LED_HOLD_CYCLES + 200;
    localparam ossc_pkg::ctrl_word_t CTRL_ISL  = 16'h4807;
    localparam ossc_pkg::ctrl_word_t CTRL_HDMI = 16'h0087;

    typedef struct packed {
        logic                 on;
        logic                 sel;
        logic                 osd_en;
        ossc_pkg::osd_color_t osd_col;
        ossc_pkg::video_t     isl;
        ossc_pkg::video_t     hdmi;
    } sample_t;

    logic                       CLK27_i;
    logic                       po_reset_n;
    logic                       pll_locked_i;
    logic                       cfg_valid_i;
    ossc_pkg::ctrl_word_t       cfg_data_i;
    logic                       cfg_ready_o;
    ossc_pkg::video_t           isl_video_i;
    ossc_pkg::video_t           hdmirx_video_i;
    logic                       osd_enable_i;
    ossc_pkg::osd_color_t       osd_color_i;
    ossc_pkg::video_t           hdmitx_video_o;
    logic [ossc_pkg::BTN_W-1:0] btn_i;
    logic                       ir_rx_i;
    logic                       resync_strobe_i;
    ossc_pkg::controls_t        controls_o;
    logic [2:0]                 led_o;
    logic                       isl_reset_n_o;
    logic                       hdmirx_reset_n_o;
    logic                       audmux_o;

    logic    stream_on;
    logic    stream_sel;
    sample_t hist[$];
    int      err_cnt;
    int      chk_cnt;

    ossc_top dut0 (.*);

    initial begin
        CLK27_i = 1'b0;
        forever #20 CLK27_i = ~CLK27_i;
    end

    function automatic ossc_pkg::video_t expect_pixel(ossc_pkg::video_t px, logic osd_en,
                                                     ossc_pkg::osd_color_t col);
        ossc_pkg::video_t res;
        res = px;
        if (osd_en) begin
            case (col)
                ossc_pkg::OSD_BLACK:  {res.r, res.g, res.b} = 24'h000000;
                ossc_pkg::OSD_BLUE:   {res.r, res.g, res.b} = 24'h0000ff;
                ossc_pkg::OSD_YELLOW: {res.r, res.g, res.b} = 24'hffff00;
                default:              {res.r, res.g, res.b} = 24'hffffff;
            endcase
        end
        if (ossc_pkg::R_LSB_FIX) begin
            res.r[0] = 1'b0;
        end
        return res;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Error %s at %0t: expected %h, actual %h", name, $time, exp, act);
        end
    endtask

    task automatic write_ctrl(ossc_pkg::ctrl_word_t w);
        int tries;
        tries = 0;
        cfg_valid_i = 1'b1;
        cfg_data_i  = w;
        while (!cfg_ready_o && tries < 100) begin
            @(negedge CLK27_i);
            tries++;
        end
        if (!cfg_ready_o) begin
            err_cnt++;
            $display("Control write %h was never accepted", w);
        end
        @(negedge CLK27_i);
        cfg_valid_i = 1'b0;
    endtask

    // receiver resets and LED follow the word, the audio select pin is inverted
    task automatic check_ctrl(ossc_pkg::ctrl_word_t w);
        check("isl reset", 32'(w[1]), 32'(isl_reset_n_o));
        check("hdmirx reset", 32'(w[2]), 32'(hdmirx_reset_n_o));
        check("audio mux", 32'(!w[11]), 32'(audmux_o));
        check("power led", 32'({w[14], ir_rx_i, 1'b0}), 32'(led_o));
    endtask

    task automatic run_stream(logic sel, logic osd_en, ossc_pkg::osd_color_t col);
        logic [31:0] rnd;
        stream_sel   = sel;
        osd_enable_i = osd_en;
        osd_color_i  = col;
        repeat (STREAM_LEN) begin
            rnd = $urandom;
            isl_video_i = rnd[26:0];
            rnd = $urandom;
            hdmirx_video_i = rnd[26:0];
            stream_on = 1'b1;
            @(negedge CLK27_i);
        end
        stream_on    = 1'b0;
        osd_enable_i = 1'b0;
        repeat (DRAIN) @(negedge CLK27_i);
    endtask

    // record what each edge sampled, compare on the following falling edge
    initial begin
        sample_t cur;
        sample_t old;
        int      lat;
        forever begin
            @(posedge CLK27_i);
            cur = {stream_on, stream_sel, osd_enable_i, osd_color_i, isl_video_i,
                   hdmirx_video_i};
            hist.push_front(cur);
            if (hist.size() > 8) begin
                void'(hist.pop_back());
            end
            @(negedge CLK27_i);
            if (hist.size() > HDMI_LAT) begin
                lat = hist[0].sel ? HDMI_LAT : ISL_LAT;
                old = hist[lat];
                if (old.on) begin
                    check(old.sel ? "hdmirx video" : "isl video",
                          32'(expect_pixel(old.sel ? old.hdmi : old.isl, hist[1].osd_en,
                                           hist[1].osd_col)),
                          32'(hdmitx_video_o));
                end
            end
        end
    end

    initial begin
        int          n;
        logic [31:0] rnd;
        logic [6:0]  prev_ctl;
        rnd = $urandom(SEED);
        err_cnt = 0;
        chk_cnt = 0;
        po_reset_n = 1'b0;
        pll_locked_i = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_data_i = '0;
        isl_video_i = '0;
        hdmirx_video_i = '0;
        osd_enable_i = 1'b0;
        osd_color_i = ossc_pkg::OSD_BLACK;
        btn_i = '1;
        ir_rx_i = 1'b1;
        resync_strobe_i = 1'b0;
        stream_on = 1'b0;
        stream_sel = 1'b0;
        repeat (4) @(negedge CLK27_i);
        po_reset_n = 1'b1;
        repeat (3) @(negedge CLK27_i);
        check("ready before lock", 32'(0), 32'(cfg_ready_o));
        pll_locked_i = 1'b1;
        n = 0;
        while (!cfg_ready_o && n < 4 * ossc_pkg::PO_HOLD_CYCLES) begin
            @(negedge CLK27_i);
            n++;
        end
        check("reset hold", ossc_pkg::PO_HOLD_CYCLES, n);
        check("led after reset", 32'(3'b001), 32'(led_o));
        check("isl reset after reset", 32'(0), 32'(isl_reset_n_o));
        check("hdmirx reset after reset", 32'(0), 32'(hdmirx_reset_n_o));

        write_ctrl(CTRL_ISL);
        check_ctrl(CTRL_ISL);
        repeat (4) @(negedge CLK27_i);
        run_stream(1'b0, 1'b0, ossc_pkg::OSD_BLACK);
        write_ctrl(CTRL_HDMI);
        check_ctrl(CTRL_HDMI);
        repeat (4) @(negedge CLK27_i);
        run_stream(1'b1, 1'b0, ossc_pkg::OSD_BLACK);
        for (int c = 0; c < 4; c++) begin
            run_stream(1'b1, 1'b1, ossc_pkg::osd_color_t'(c));
        end

        // the old level must still show one cycle after the change
        repeat (4) begin
            prev_ctl = {btn_i, ir_rx_i};
            rnd = $urandom;
            btn_i = rnd[5:0];
            ir_rx_i = rnd[6];
            @(negedge CLK27_i);
            check("buttons and ir early", 32'(prev_ctl), 32'(controls_o));
            @(negedge CLK27_i);
            check("buttons and ir", 32'({btn_i, ir_rx_i}), 32'(controls_o));
            check("ir idle led", 32'(ir_rx_i), 32'(led_o[1]));
        end
        btn_i = '1;
        ir_rx_i = 1'b1;
        repeat (2) @(negedge CLK27_i);

        resync_strobe_i = 1'b1;
        n = 0;
        while (!led_o[0] && n < 10) begin
            @(negedge CLK27_i);
            n++;
        end
        check("resync led delay", 32'(3), n);
        resync_strobe_i = 1'b0;
        n = 0;
        while (led_o[0] && n < 2 * ossc_pkg::LED_HOLD_CYCLES) begin
            @(negedge CLK27_i);
            n++;
        end
        check("resync led length", ossc_pkg::LED_HOLD_CYCLES, n);

        $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK27_i);
        $display("Timeout, the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ossc_assert.sv ====
/*
 * Concurrent checks bound into ossc_top.
 * All of them are off while the power-on reset is low.
 */
`default_nettype none

module ossc_assert (
    input wire              CLK27_i,
    input wire              po_reset_n,
    input wire              sys_rst_n,
    input wire              cfg_ready_o,
    input wire              poweron,
    input wire [2:0]        led_o,
    input ossc_pkg::video_t hdmitx_video_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // the write port stays closed during the system reset
    a_ready_in_reset: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n) !sys_rst_n |-> !cfg_ready_o
    ) else $error("cfg_ready_o is high while the system reset is active");

    a_led_poweroff: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n) !poweron |-> led_o == ossc_pkg::LED_POWEROFF
    ) else $error("led_o does not show the power-off pattern while powered off");

    a_red_lsb: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n)
            ossc_pkg::R_LSB_FIX |-> hdmitx_video_o.r[0] == 1'b0
    ) else $error("red LSB of the output pixel is set");

endmodule

bind ossc_top ossc_assert u_ossc_assert (
    .CLK27_i        (CLK27_i),
    .po_reset_n     (po_reset_n),
    .sys_rst_n      (sys_rst_n),
    .cfg_ready_o    (cfg_ready_o),
    .poweron        (ctrl.poweron),
    .led_o          (led_o),
    .hdmitx_video_o (hdmitx_video_o)
);

`default_nettype wire

// ==== logic/ossc_top.sv ====
/*
 * FPGA top level glue on a single 27 MHz clock. Video latency is 4
 * cycles from the ISL input and 5 from the HDMI RX input. Software
 * must wait for cfg_ready_o before the first control write.
 */
`default_nettype none

module ossc_top (
    input  wire                        CLK27_i,
    input  wire                        po_reset_n,
    input  wire                        pll_locked_i,

    input  wire                        cfg_valid_i,
    input  ossc_pkg::ctrl_word_t       cfg_data_i,
    output logic                       cfg_ready_o,

    input  ossc_pkg::video_t           isl_video_i,
    input  ossc_pkg::video_t           hdmirx_video_i,
    input  wire                        osd_enable_i,
    input  ossc_pkg::osd_color_t       osd_color_i,
    output ossc_pkg::video_t           hdmitx_video_o,

    input  wire [ossc_pkg::BTN_W-1:0]  btn_i,
    input  wire                        ir_rx_i,
    input  wire                        resync_strobe_i,
    output ossc_pkg::controls_t        controls_o,
    output logic [2:0]                 led_o,

    output logic                       isl_reset_n_o,
    output logic                       hdmirx_reset_n_o,
    output logic                       audmux_o
);

    logic                sys_rst_n;
    ossc_pkg::sys_ctrl_t ctrl;
    ossc_pkg::video_t    cap_video;

    sys_reset_gen u_sys_reset_gen (
        .CLK27_i      (CLK27_i),
        .po_reset_n   (po_reset_n),
        .pll_locked_i (pll_locked_i),
        .sys_rst_n_o  (sys_rst_n)
    );

    sys_ctrl_regs u_sys_ctrl_regs (
        .CLK27_i     (CLK27_i),
        .po_reset_n  (po_reset_n),
        .sys_rst_n_i (sys_rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_ready_o (cfg_ready_o),
        .ctrl_o      (ctrl)
    );

    front_panel u_front_panel (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .sys_rst_n_i     (sys_rst_n),
        .btn_i           (btn_i),
        .ir_rx_i         (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .ctrl_i          (ctrl),
        .controls_o      (controls_o),
        .led_o           (led_o)
    );

    capture_mux u_capture_mux (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .sys_rst_n_i    (sys_rst_n),
        .isl_video_i    (isl_video_i),
        .hdmirx_video_i (hdmirx_video_i),
        .capture_sel_i  (ctrl.capture_sel),
        .cap_video_o    (cap_video)
    );

    // capture feeds the output stage directly, no scaler in between
    osd_overlay u_osd_overlay (
        .CLK27_i      (CLK27_i),
        .po_reset_n   (po_reset_n),
        .sys_rst_n_i  (sys_rst_n),
        .video_i      (cap_video),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .video_o      (hdmitx_video_o)
    );

    assign isl_reset_n_o    = ctrl.isl_reset_n;
    assign hdmirx_reset_n_o = ctrl.hdmirx_reset_n;
    // the audio mux select pin is active low on the board
    assign audmux_o         = ~ctrl.audmux_sel;

endmodule

`default_nettype wire

// ==== logic/osd_overlay.sv ====
/*
 * Output stage, 2 cycles. OSD enable and colour must be aligned with
 * video_i. Syncs and DE are never touched by the overlay.
 */
`default_nettype none

module osd_overlay (
    input  wire                  CLK27_i,
    input  wire                  po_reset_n,
    input  wire                  sys_rst_n_i,
    input  ossc_pkg::video_t     video_i,
    input  wire                  osd_enable_i,
    input  ossc_pkg::osd_color_t osd_color_i,
    output ossc_pkg::video_t     video_o
);

    ossc_pkg::video_t mix_q;
    ossc_pkg::video_t out_q;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_q <= '0;
        end else if (!sys_rst_n_i) begin
            mix_q <= '0;
        end else begin
            if (osd_enable_i) begin
                {mix_q.r, mix_q.g, mix_q.b} <= ossc_pkg::OSD_PALETTE[osd_color_i];
            end else begin
                {mix_q.r, mix_q.g, mix_q.b} <= {video_i.r, video_i.g, video_i.b};
            end
            mix_q.hsync <= video_i.hsync;
            mix_q.vsync <= video_i.vsync;
            mix_q.de    <= video_i.de;
        end
    end

    // second stage replaces the negedge launch toward the transmitter
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            out_q <= '0;
        end else if (!sys_rst_n_i) begin
            out_q <= '0;
        end else begin
            out_q   <= mix_q;
            out_q.r <= ossc_pkg::R_LSB_FIX ? {mix_q.r[7:1], 1'b0} : mix_q.r;
        end
    end

    assign video_o = out_q;

endmodule

`default_nettype wire

// ==== logic/capture_mux.sv ====
/*
 * Capture source select. Both receivers are assumed to be retimed to
 * the system clock already. ISL latency is 2 cycles, HDMI RX 3 cycles.
 * Switching capture_sel_i mixes pixels of the two sources for a few cycles.
 */
`default_nettype none

module capture_mux (
    input  wire              CLK27_i,
    input  wire              po_reset_n,
    input  wire              sys_rst_n_i,
    input  ossc_pkg::video_t isl_video_i,
    input  ossc_pkg::video_t hdmirx_video_i,
    input  wire              capture_sel_i,
    output ossc_pkg::video_t cap_video_o
);

    ossc_pkg::video_t isl_q;
    ossc_pkg::video_t hdmirx_q1;
    ossc_pkg::video_t hdmirx_q2;
    ossc_pkg::video_t cap_q;

    // input registers, the HDMI RX side keeps its extra stage
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_q     <= '0;
            hdmirx_q1 <= '0;
            hdmirx_q2 <= '0;
        end else if (!sys_rst_n_i) begin
            isl_q     <= '0;
            hdmirx_q1 <= '0;
            hdmirx_q2 <= '0;
        end else begin
            isl_q     <= isl_video_i;
            hdmirx_q1 <= hdmirx_video_i;
            hdmirx_q2 <= hdmirx_q1;
        end
    end

    // 0 selects the digitizer, 1 the HDMI receiver
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap_q <= '0;
        end else if (!sys_rst_n_i) begin
            cap_q <= '0;
        end else begin
            cap_q <= capture_sel_i ? hdmirx_q2 : isl_q;
        end
    end

    assign cap_video_o = cap_q;

endmodule

`default_nettype wire

// ==== logic/front_panel.sv ====
/*
 * Buttons, IR and resync strobe are treated as asynchronous and pass
 * through two flops each. Buttons and IR idle high.
 * The resync LED lights 3 cycles after a strobe edge, for LED_HOLD_CYCLES.
 */
`default_nettype none

module front_panel (
    input  wire                        CLK27_i,
    input  wire                        po_reset_n,
    input  wire                        sys_rst_n_i,
    input  wire [ossc_pkg::BTN_W-1:0]  btn_i,
    input  wire                        ir_rx_i,
    input  wire                        resync_strobe_i,
    input  ossc_pkg::sys_ctrl_t        ctrl_i,
    output ossc_pkg::controls_t        controls_o,
    output logic [2:0]                 led_o
);

    logic [ossc_pkg::BTN_W-1:0] btn_sync1;
    logic [ossc_pkg::BTN_W-1:0] btn_sync2;
    logic                       ir_sync1;
    logic                       ir_sync2;
    logic                       resync_sync1;
    logic                       resync_sync2;
    logic                       resync_prev;
    logic                       resync_rise;
    logic [ossc_pkg::LED_CNT_W-1:0] led_cnt;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1 <= '1;
            btn_sync2 <= '1;
            ir_sync1  <= 1'b1;
            ir_sync2  <= 1'b1;
        end else if (!sys_rst_n_i) begin
            btn_sync1 <= '1;
            btn_sync2 <= '1;
            ir_sync1  <= 1'b1;
            ir_sync2  <= 1'b1;
        end else begin
            btn_sync1 <= btn_i;
            btn_sync2 <= btn_sync1;
            ir_sync1  <= ir_rx_i;
            ir_sync2  <= ir_sync1;
        end
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
            resync_prev  <= 1'b0;
            led_cnt      <= '0;
        end else if (!sys_rst_n_i) begin
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
            resync_prev  <= 1'b0;
            led_cnt      <= '0;
        end else begin
            resync_sync1 <= resync_strobe_i;
            resync_sync2 <= resync_sync1;
            resync_prev  <= resync_sync2;
            // a new edge restarts the stretch
            if (resync_rise) begin
                led_cnt <= ossc_pkg::LED_CNT_W'(ossc_pkg::LED_HOLD_CYCLES);
            end else if (led_cnt != '0) begin
                led_cnt <= led_cnt - 1'b1;
            end
        end
    end

    assign resync_rise = resync_sync2 & ~resync_prev;

    assign controls_o.btn = btn_sync2;
    assign controls_o.ir  = ir_sync2;

    // bit 2 adaptive LM, bit 1 IR idle, bit 0 resync
    assign led_o = ctrl_i.poweron ? {ctrl_i.adap_lm, ir_sync2, (led_cnt != '0)}
                                  : ossc_pkg::LED_POWEROFF;

endmodule

`default_nettype wire

// ==== logic/sys_ctrl_regs.sv ====
/*
 * System control register written over a valid/ready port.
 * Writes are refused while the system reset is active, and the
 * register is cleared for as long as it lasts.
 */
`default_nettype none

module sys_ctrl_regs (
    input  wire                  CLK27_i,
    input  wire                  po_reset_n,
    input  wire                  sys_rst_n_i,
    input  wire                  cfg_valid_i,
    input  ossc_pkg::ctrl_word_t cfg_data_i,
    output logic                 cfg_ready_o,
    output ossc_pkg::sys_ctrl_t  ctrl_o
);

    ossc_pkg::sys_ctrl_t ctrl_q;
    logic                wr_en;

    // always ready once out of reset
    assign cfg_ready_o = sys_rst_n_i;
    assign wr_en       = cfg_valid_i & cfg_ready_o;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_q <= '0;
        end else if (!sys_rst_n_i) begin
            ctrl_q <= '0;
        end else if (wr_en) begin
            ctrl_q <= ossc_pkg::sys_ctrl_t'(cfg_data_i);
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// ==== logic/sys_reset_gen.sv ====
/*
 * System reset is released PO_HOLD_CYCLES edges after power-on reset and
 * PLL lock are both present. Losing either asserts it again at once.
 */
`default_nettype none

module sys_reset_gen (
    input  wire  CLK27_i,
    input  wire  po_reset_n,
    input  wire  pll_locked_i,
    output logic sys_rst_n_o
);

    logic [ossc_pkg::PO_CNT_W-1:0] hold_cnt;
    logic                          hold_done;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_cnt  <= '0;
            hold_done <= 1'b0;
        end else if (!pll_locked_i) begin
            // lock lost, start the hold over
            hold_cnt  <= '0;
            hold_done <= 1'b0;
        end else if (!hold_done) begin
            if (hold_cnt == ossc_pkg::PO_CNT_W'(ossc_pkg::PO_HOLD_CYCLES - 1)) begin
                hold_done <= 1'b1;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    // drop without waiting for an edge
    assign sys_rst_n_o = hold_done & po_reset_n & pll_locked_i;

endmodule

`default_nettype wire

// ==== logic/ossc_pkg.sv ====
/*
 * Shared types and constants for the scan converter glue logic.
 * Everything runs on the 27 MHz system clock.
 */
`default_nettype none

package ossc_pkg;

    // one pixel with its syncs, as it leaves a receiver
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hsync;
        logic       vsync;
        logic       de;
    } video_t;

    // bit layout matches the 16-bit control word written by software
    typedef struct packed {
        logic       rsvd15;
        logic       adap_lm;
        logic [1:0] rsvd13_12;
        logic       audmux_sel;
        logic [2:0] rsvd10_8;
        logic       capture_sel;
        logic [3:0] rsvd6_3;
        logic       hdmirx_reset_n;
        logic       isl_reset_n;
        logic       poweron;
    } sys_ctrl_t;

    typedef logic [15:0] ctrl_word_t;

    localparam int BTN_W = 6;

    typedef struct packed {
        logic [BTN_W-1:0] btn;
        logic             ir;
    } controls_t;

    typedef enum logic [1:0] {
        OSD_BLACK,
        OSD_BLUE,
        OSD_YELLOW,
        OSD_WHITE
    } osd_color_t;

    localparam int PO_HOLD_CYCLES = 32;
    localparam int PO_CNT_W       = $clog2(PO_HOLD_CYCLES);
    localparam int LED_HOLD_CYCLES = 200;
    localparam int LED_CNT_W      = 8;

    // board SI fix, red LSB is forced low at the HDMI TX pins
    localparam bit R_LSB_FIX = 1'b1;

    localparam logic [2:0] LED_POWEROFF = 3'b001;

    // indexed by osd_color_t
    localparam logic [23:0] OSD_PALETTE [0:3] = '{
        24'h000000,
        24'h0000ff,
        24'hffff00,
        24'hffffff
    };

endpackage

`default_nettype wire
